// File: api_router.sv
// Host API router
// Splits the host address into port and register index, strobes the
// selected port bank on acceptance and queues one response per request.
// Malformed requests are answered here and never reach a bank
`timescale 1ns/1ps

module api_router import ntps_pkg::*; (
  input  logic                            clk156,
  input  logic                            reset,
  input  api_req_t                        api_req,
  input  logic                            api_req_valid,
  output logic                            api_req_ready,
  output api_rsp_t                        api_rsp,
  output logic                            api_rsp_valid,
  input  logic                            api_rsp_ready,
  output logic [NUM_PORTS-1:0]            reg_wr,
  output logic [NUM_PORTS-1:0]            reg_rd,
  output logic [REG_IDX_W-1:0]            reg_idx,
  output logic [REG_W-1:0]                wr_data,
  input  logic [NUM_PORTS-1:0][REG_W-1:0] rd_data,
  input  logic [NUM_PORTS-1:0]            reg_err
);

  logic [PORT_SEL_W-1:0] port_sel;
  logic                  addr_hi_set;
  logic                  cmd_known;
  logic                  local_err;
  logic                  accept;
  api_rsp_t              rsp_next;

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  assign port_sel    = api_req.address[PORT_SEL_LSB +: PORT_SEL_W];
  assign addr_hi_set = |api_req.address[REG_W-1:PORT_SEL_LSB+PORT_SEL_W];
  assign cmd_known   = (api_req.cmd == READ) || (api_req.cmd == WRITE);
  assign local_err   = addr_hi_set | ~cmd_known;

  assign reg_idx = api_req.address[REG_IDX_W-1:0];
  assign wr_data = api_req.write_data;

  // Ready follows free space in the response queue
  assign accept = api_req_valid & api_req_ready;

  always_comb begin
    reg_wr = '0;
    reg_rd = '0;
    if (accept && !local_err) begin
      reg_wr[port_sel] = (api_req.cmd == WRITE);
      reg_rd[port_sel] = (api_req.cmd == READ);
    end
  end

  // Errors carry zero data
  always_comb begin
    rsp_next.status    = OK;
    rsp_next.read_data = '0;
    if (local_err || reg_err[port_sel]) begin
      rsp_next.status = ERROR;
    end else begin
      rsp_next.read_data = rd_data[port_sel];
    end
  end

  stream_buf #(
    .T (api_rsp_t)
  ) u_rsp_buf (
    .clk156    (clk156),
    .reset     (reset),
    .in_data   (rsp_next),
    .in_valid  (api_req_valid),
    .in_ready  (api_req_ready),
    .out_data  (api_rsp),
    .out_valid (api_rsp_valid),
    .out_ready (api_rsp_ready)
  );

endmodule

// File: ntp_clock.sv
// NTP time counter
// Runs a 32.32 seconds/fraction count on clk156, steps the fraction each
// cycle and rolls seconds on the rising edge of the synchronized PPS
`timescale 1ns/1ps

module ntp_clock import ntps_pkg::*; (
  input  logic      clk156,
  input  logic      reset,
  input  logic      pps_in,
  output ntp_time_t ntp_time,
  output logic      sync_ok
);

  logic      pps_meta;
  logic      pps_sync;
  logic      pps_last;
  logic      pps_rise;
  ntp_time_t time_q;

  // ------------------------------------------------
  // PPS synchronizer and edge detect
  // ------------------------------------------------
  always_ff @(posedge clk156) begin
    if (reset) begin
      pps_meta <= 1'b0;
      pps_sync <= 1'b0;
      pps_last <= 1'b0;
    end else begin
      pps_meta <= pps_in;
      pps_sync <= pps_meta;
      pps_last <= pps_sync;
    end
  end

  assign pps_rise = pps_sync & ~pps_last;

  // ------------------------------------------------
  // Time counter
  // ------------------------------------------------
  always_ff @(posedge clk156) begin
    if (reset) begin
      time_q  <= '0;
      sync_ok <= 1'b0;
    end else if (pps_rise) begin
      time_q.seconds  <= time_q.seconds + 32'd1;
      time_q.fraction <= '0;
      // Stays set once the first PPS has been seen
      sync_ok         <= 1'b1;
    end else begin
      // Free running; wraps only if PPS goes missing
      time_q.fraction <= time_q.fraction + FRAC_STEP;
    end
  end

  assign ntp_time = time_q;

  // Seconds move only on a PPS edge
  assert property (@(posedge clk156) disable iff (reset)
    !pps_rise |=> $stable(time_q.seconds))
    else $error("ntp_clock seconds changed without a PPS edge");

endmodule

// File: ntps_pkg.sv
// NTP server core definitions
// Widths, port count, host register map, and the time and host bus
// types shared by the timekeeping and register blocks
package ntps_pkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------
  localparam int NUM_PORTS    = 4;
  localparam int PORT_SEL_W   = 2;
  localparam int PORT_SEL_LSB = 8;
  localparam int REG_IDX_W    = 8;
  localparam int REG_W        = 32;
  localparam int DROP_W       = 8;

  // Fraction step per clk156 cycle, close to 2^32 / 156.25e6
  localparam logic [31:0] FRAC_STEP = 32'd27;

  // ------------------------------------------------
  // Register map
  // ------------------------------------------------
  localparam logic [REG_IDX_W-1:0] REG_NTP_CONFIG = 8'd0;
  localparam logic [REG_IDX_W-1:0] REG_RX_OFS     = 8'd1;
  localparam logic [REG_IDX_W-1:0] REG_STATUS     = 8'd2;

  localparam int CFG_TS_EN_BIT = 0;

  // Status word fields
  localparam int STAT_SYNC_BIT = 0;
  localparam int STAT_DROP_LSB = 8;

  // ------------------------------------------------
  // Types
  // ------------------------------------------------
  typedef struct packed {
    logic [31:0] seconds;
    logic [31:0] fraction;
  } ntp_time_t;

  typedef enum logic [1:0] {
    NOP   = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } api_cmd_e;

  typedef enum logic [1:0] {
    OK    = 2'd0,
    ERROR = 2'd1
  } api_status_e;

  typedef struct packed {
    api_cmd_e    cmd;
    logic [31:0] address;
    logic [31:0] write_data;
  } api_req_t;

  typedef struct packed {
    api_status_e status;
    logic [31:0] read_data;
  } api_rsp_t;

endpackage

// File: ntps_tb.sv
// Testbench for the NTP server core
// Drives the host API, PPS and receive markers, and checks registers,
// error answers, time keeping, timestamps and back-pressure
`timescale 1ns/1ps

module ntps_tb import ntps_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam logic [31:0] SEED = 32'haa55_5597;
  // Rough length of each test in cycles, plus margin
  localparam int RESET_CYC = 20;
  localparam int REG_CYC   = 60;
  localparam int STALL_CYC = 20;
  localparam int ERR_CYC   = 50;
  localparam int PPS_CYC   = 50;
  localparam int TS_CYC    = 30;
  localparam int BP_CYC    = 40;
  localparam int RUN_CYC   = RESET_CYC + REG_CYC + STALL_CYC + ERR_CYC + PPS_CYC + TS_CYC
                             + BP_CYC + 200;

  logic                      clk156;
  logic                      reset;
  logic                      pps_in;
  api_req_t                  api_req;
  logic                      api_req_valid;
  logic                      api_req_ready;
  api_rsp_t                  api_rsp;
  logic                      api_rsp_valid;
  logic                      api_rsp_ready;
  logic [NUM_PORTS-1:0]      rx_mark;
  ntp_time_t [NUM_PORTS-1:0] ts_data;
  logic [NUM_PORTS-1:0]      ts_valid;
  logic [NUM_PORTS-1:0]      ts_ready;
  ntp_time_t                 ntp_time;
  logic                      sync_ok;

  logic [31:0] cfg_model [NUM_PORTS];
  logic [31:0] ofs_model [NUM_PORTS];
  int          err_count = 0;

  ntps_top u_ntps_top (.*);

  initial begin
    clk156 = 1'b0;
    forever #(CLK_PERIOD / 2) clk156 = ~clk156;
  end

  // --------------------------------------------------
  // Checking helpers
  // --------------------------------------------------
  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    err_count++;
    $display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
    $display("STATUS: FAIL");
    $fatal(1, "%s mismatch", name);
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else report_mismatch(name, exp, act);
  endtask

  function automatic logic [31:0] port_addr(input int port, input logic [7:0] idx);
    return (32'(port) << PORT_SEL_LSB) | 32'(idx);
  endfunction

  // Offset lands on the fraction, carry into seconds
  function automatic ntp_time_t add_offset(input ntp_time_t t, input logic [31:0] ofs);
    ntp_time_t   sum;
    logic [32:0] frac_sum;
    frac_sum     = {1'b0, t.fraction} + {1'b0, ofs};
    sum.fraction = frac_sum[31:0];
    sum.seconds  = t.seconds + {31'd0, frac_sum[32]};
    return sum;
  endfunction

  // Response one cycle after acceptance
  assert property (@(posedge clk156) disable iff (reset)
    (api_req_valid && api_req_ready) |=> api_rsp_valid)
    else report_mismatch("rsp_latency", 1, api_rsp_valid);

  assert property (@(posedge clk156) disable iff (reset)
    $changed(ntp_time.seconds) |-> (ntp_time.fraction == 32'd0) && sync_ok)
    else report_mismatch("pps_fraction_restart", 0, ntp_time.fraction);

  assert property (@(posedge clk156) disable iff (reset)
    $changed(ntp_time.seconds) |-> ntp_time.seconds == $past(ntp_time.seconds) + 32'd1)
    else report_mismatch("pps_seconds_step", 1, ntp_time.seconds);

  // Ports 0 and 2 never have timestamping on
  assert property (@(posedge clk156) disable iff (reset)
    !ts_valid[0] && !ts_valid[2])
    else report_mismatch("ts_disabled_ports", 0, {ts_valid[2], ts_valid[0]});

  // --------------------------------------------------
  // Host bus and stimulus
  // --------------------------------------------------
  task automatic send_req(input api_cmd_e req_cmd, input logic [31:0] req_addr,
                          input logic [31:0] req_data);
    @(posedge clk156);
    api_req       <= '{cmd: req_cmd, address: req_addr, write_data: req_data};
    api_req_valid <= 1'b1;
    @(negedge clk156);
    while (!api_req_ready) @(negedge clk156);
    @(posedge clk156);
    api_req_valid <= 1'b0;
  endtask

  task automatic get_rsp(output api_rsp_t rsp);
    @(negedge clk156);
    while (!(api_rsp_valid && api_rsp_ready)) @(negedge clk156);
    rsp = api_rsp;
    @(posedge clk156);
  endtask

  task automatic host_access(input api_cmd_e req_cmd, input logic [31:0] req_addr,
                             input logic [31:0] req_data, output api_rsp_t rsp);
    send_req(req_cmd, req_addr, req_data);
    get_rsp(rsp);
  endtask

  task automatic expect_error(input string name, input api_rsp_t rsp);
    check_eq({name, "_status"}, ERROR, rsp.status);
    check_eq({name, "_data"}, 0, rsp.read_data);
  endtask

  // Marker is sampled at the second edge; time seen just before it
  task automatic pulse_mark(input logic [NUM_PORTS-1:0] mask, output ntp_time_t seen);
    @(posedge clk156);
    rx_mark <= mask;
    @(negedge clk156);
    seen = ntp_time;
    @(posedge clk156);
    rx_mark <= '0;
  endtask

  task automatic pps_pulse();
    ntp_time_t prev_time;
    @(negedge clk156);
    prev_time = ntp_time;
    @(posedge clk156);
    pps_in <= 1'b1;
    @(negedge clk156);
    while (ntp_time.seconds == prev_time.seconds) @(negedge clk156);
    check_eq("pps_seconds", prev_time.seconds + 32'd1, ntp_time.seconds);
    check_eq("pps_fraction", 0, ntp_time.fraction);
    check_eq("pps_sync_ok", 1, sync_ok);
    @(posedge clk156);
    pps_in <= 1'b0;
    repeat (4) @(posedge clk156);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic check_reset_state();
    api_rsp_t rsp;
    @(negedge clk156);
    check_eq("reset_rsp_valid", 0, api_rsp_valid);
    check_eq("reset_ts_valid", 0, ts_valid);
    check_eq("reset_req_ready", 1, api_req_ready);
    for (int p = 0; p < NUM_PORTS; p++) begin
      host_access(READ, port_addr(p, REG_STATUS), 32'd0, rsp);
      check_eq("reset_status_ok", OK, rsp.status);
      check_eq("reset_status_data", 0, rsp.read_data);
    end
  endtask

  task automatic exercise_registers();
    api_rsp_t rsp;
    // Timestamping stays off here
    for (int p = 0; p < NUM_PORTS; p++) begin
      cfg_model[p] = $urandom & ~32'h1;
      ofs_model[p] = $urandom;
      host_access(WRITE, port_addr(p, REG_NTP_CONFIG), cfg_model[p], rsp);
      check_eq("reg_write_ok", OK, rsp.status);
      host_access(WRITE, port_addr(p, REG_RX_OFS), ofs_model[p], rsp);
      check_eq("reg_write_ok", OK, rsp.status);
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      host_access(READ, port_addr(p, REG_NTP_CONFIG), 32'd0, rsp);
      check_eq("reg_config_readback", cfg_model[p], rsp.read_data);
      host_access(READ, port_addr(p, REG_RX_OFS), 32'd0, rsp);
      check_eq("reg_rx_ofs_readback", ofs_model[p], rsp.read_data);
    end
  endtask

  task automatic stall_responses();
    api_rsp_t rsp;
    @(posedge clk156);
    api_rsp_ready <= 1'b0;
    send_req(READ, port_addr(0, REG_NTP_CONFIG), 32'd0);
    send_req(READ, port_addr(1, REG_NTP_CONFIG), 32'd0);
    fork
      send_req(READ, port_addr(2, REG_NTP_CONFIG), 32'd0);
      begin
        repeat (3) @(negedge clk156);
        check_eq("stall_req_ready", 0, api_req_ready);
        check_eq("stall_rsp_valid", 1, api_rsp_valid);
        @(posedge clk156);
        api_rsp_ready <= 1'b1;
        for (int p = 0; p < 3; p++) begin
          get_rsp(rsp);
          check_eq("stall_order", cfg_model[p], rsp.read_data);
        end
      end
    join
  endtask

  task automatic reject_bad_requests();
    api_rsp_t rsp;
    host_access(READ, port_addr(0, 8'd3), 32'd0, rsp);
    expect_error("err_bad_index", rsp);
    host_access(WRITE, port_addr(1, REG_STATUS), $urandom, rsp);
    expect_error("err_status_write", rsp);
    host_access(WRITE, 32'h0001_0000 | port_addr(2, REG_NTP_CONFIG), $urandom, rsp);
    expect_error("err_addr_high", rsp);
    host_access(NOP, port_addr(3, REG_RX_OFS), $urandom, rsp);
    expect_error("err_nop", rsp);
    // Nothing above may have changed a register
    for (int p = 0; p < NUM_PORTS; p++) begin
      host_access(READ, port_addr(p, REG_NTP_CONFIG), 32'd0, rsp);
      check_eq("err_config_kept", cfg_model[p], rsp.read_data);
      host_access(READ, port_addr(p, REG_RX_OFS), 32'd0, rsp);
      check_eq("err_rx_ofs_kept", ofs_model[p], rsp.read_data);
    end
  endtask

  task automatic follow_pps();
    api_rsp_t rsp;
    @(negedge clk156);
    check_eq("sync_before_pps", 0, sync_ok);
    repeat (2) pps_pulse();
    for (int p = 0; p < NUM_PORTS; p++) begin
      host_access(READ, port_addr(p, REG_STATUS), 32'd0, rsp);
      check_eq("pps_status_sync", 32'h1, rsp.read_data);
    end
  endtask

  task automatic capture_timestamps();
    api_rsp_t  rsp;
    ntp_time_t seen;
    ntp_time_t expected;
    cfg_model[1] = cfg_model[1] | 32'h1;
    // Offset near the top of the fraction range so the sum carries into seconds
    ofs_model[1] = 32'hFFFF_FF00 | ($urandom & 32'hFF);
    host_access(WRITE, port_addr(1, REG_NTP_CONFIG), cfg_model[1], rsp);
    host_access(WRITE, port_addr(1, REG_RX_OFS), ofs_model[1], rsp);
    repeat (2) begin
      // Every port sees the marker, only port 1 is enabled
      pulse_mark('1, seen);
      expected = add_offset(seen, ofs_model[1]);
      @(negedge clk156);
      check_eq("ts_valid", 4'b0010, ts_valid);
      check_eq("ts_value", expected, ts_data[1]);
      @(negedge clk156);
      check_eq("ts_drained", 4'b0000, ts_valid);
    end
  endtask

  task automatic hold_timestamps();
    api_rsp_t  rsp;
    ntp_time_t seen;
    ntp_time_t expected [3];
    @(posedge clk156);
    ts_ready[3] <= 1'b0;
    cfg_model[3] = cfg_model[3] | 32'h1;
    ofs_model[3] = $urandom;
    host_access(WRITE, port_addr(3, REG_NTP_CONFIG), cfg_model[3], rsp);
    host_access(WRITE, port_addr(3, REG_RX_OFS), ofs_model[3], rsp);
    for (int k = 0; k < 3; k++) begin
      pulse_mark(4'b1000, seen);
      expected[k] = add_offset(seen, ofs_model[3]);
    end
    // Drop count 1 in bits 15:8, sync bit set
    host_access(READ, port_addr(3, REG_STATUS), 32'd0, rsp);
    check_eq("bp_drop_count", (32'd1 << 8) | 32'd1, rsp.read_data);
    @(posedge clk156);
    ts_ready[3] <= 1'b1;
    for (int k = 0; k < 2; k++) begin
      @(negedge clk156);
      check_eq("bp_valid", 1, ts_valid[3]);
      check_eq("bp_order", expected[k], ts_data[3]);
    end
    @(negedge clk156);
    check_eq("bp_empty", 0, ts_valid[3]);
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    void'($urandom(SEED));
    reset         = 1'b1;
    pps_in        = 1'b0;
    api_req       = '0;
    api_req_valid = 1'b0;
    api_rsp_ready = 1'b1;
    rx_mark       = '0;
    ts_ready      = '1;
    repeat (2) @(posedge clk156);
    reset <= 1'b0;
    check_reset_state();
    exercise_registers();
    stall_responses();
    reject_bad_requests();
    follow_pps();
    capture_timestamps();
    hold_timestamps();
    repeat (2) @(posedge clk156);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(RUN_CYC * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

endmodule

// File: ntps_top.sv
// NTP server timekeeping and register core
// Shared NTP clock, host API router and four network ports, each with
// a register bank and a receive timestamp unit, all on clk156
`timescale 1ns/1ps

module ntps_top import ntps_pkg::*; (
  input  logic                        clk156,
  input  logic                        reset,
  input  logic                        pps_in,
  input  api_req_t                    api_req,
  input  logic                        api_req_valid,
  output logic                        api_req_ready,
  output api_rsp_t                    api_rsp,
  output logic                        api_rsp_valid,
  input  logic                        api_rsp_ready,
  input  logic [NUM_PORTS-1:0]        rx_mark,
  output ntp_time_t [NUM_PORTS-1:0]   ts_data,
  output logic [NUM_PORTS-1:0]        ts_valid,
  input  logic [NUM_PORTS-1:0]        ts_ready,
  output ntp_time_t                   ntp_time,
  output logic                        sync_ok
);

  logic [NUM_PORTS-1:0]             reg_wr;
  logic [NUM_PORTS-1:0]             reg_rd;
  logic [REG_IDX_W-1:0]             reg_idx;
  logic [REG_W-1:0]                 wr_data;
  logic [NUM_PORTS-1:0][REG_W-1:0]  rd_data;
  logic [NUM_PORTS-1:0]             reg_err;
  logic [NUM_PORTS-1:0]             ts_en;
  logic [NUM_PORTS-1:0][REG_W-1:0]  rx_ofs;
  logic [NUM_PORTS-1:0][DROP_W-1:0] drop_count;

  ntp_clock u_ntp_clock (
    .clk156   (clk156),
    .reset    (reset),
    .pps_in   (pps_in),
    .ntp_time (ntp_time),
    .sync_ok  (sync_ok)
  );

  api_router u_api_router (
    .clk156        (clk156),
    .reset         (reset),
    .api_req       (api_req),
    .api_req_valid (api_req_valid),
    .api_req_ready (api_req_ready),
    .api_rsp       (api_rsp),
    .api_rsp_valid (api_rsp_valid),
    .api_rsp_ready (api_rsp_ready),
    .reg_wr        (reg_wr),
    .reg_rd        (reg_rd),
    .reg_idx       (reg_idx),
    .wr_data       (wr_data),
    .rd_data       (rd_data),
    .reg_err       (reg_err)
  );

  // ------------------------------------------------
  // Network ports
  // ------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    port_regs u_port_regs (
      .clk156     (clk156),
      .reset      (reset),
      .reg_wr     (reg_wr[p]),
      .reg_rd     (reg_rd[p]),
      .reg_idx    (reg_idx),
      .wr_data    (wr_data),
      .sync_ok    (sync_ok),
      .drop_count (drop_count[p]),
      .rd_data    (rd_data[p]),
      .reg_err    (reg_err[p]),
      .ts_en      (ts_en[p]),
      .rx_ofs     (rx_ofs[p])
    );

    port_timestamp u_port_timestamp (
      .clk156     (clk156),
      .reset      (reset),
      .rx_mark    (rx_mark[p]),
      .ts_en      (ts_en[p]),
      .rx_ofs     (rx_ofs[p]),
      .ntp_time   (ntp_time),
      .ts_data    (ts_data[p]),
      .ts_valid   (ts_valid[p]),
      .ts_ready   (ts_ready[p]),
      .drop_count (drop_count[p])
    );
  end

endmodule

// File: port_regs.sv
// Per-port register bank
// Holds the NTP config and receive offset of one network port and
// builds the read-only status word from sync state and drop count.
// Reads and writes are answered in the cycle of the strobe
`timescale 1ns/1ps

module port_regs import ntps_pkg::*; (
  input  logic                 clk156,
  input  logic                 reset,
  input  logic                 reg_wr,
  input  logic                 reg_rd,
  input  logic [REG_IDX_W-1:0] reg_idx,
  input  logic [REG_W-1:0]     wr_data,
  input  logic                 sync_ok,
  input  logic [DROP_W-1:0]    drop_count,
  output logic [REG_W-1:0]     rd_data,
  output logic                 reg_err,
  output logic                 ts_en,
  output logic [REG_W-1:0]     rx_ofs
);

  logic [REG_W-1:0] ntp_config;
  logic [REG_W-1:0] status_word;

  // ------------------------------------------------
  // Writable registers
  // ------------------------------------------------
  always_ff @(posedge clk156) begin
    if (reset) begin
      ntp_config <= '0;
      rx_ofs     <= '0;
    end else if (reg_wr) begin
      case (reg_idx)
        REG_NTP_CONFIG: ntp_config <= wr_data;
        REG_RX_OFS:     rx_ofs     <= wr_data;
        default: ;
      endcase
    end
  end

  assign ts_en = ntp_config[CFG_TS_EN_BIT];

  // Status word, unused bits read zero
  always_comb begin
    status_word = '0;
    status_word[STAT_SYNC_BIT] = sync_ok;
    status_word[STAT_DROP_LSB +: DROP_W] = drop_count;
  end

  // ------------------------------------------------
  // Read mux and error decode
  // ------------------------------------------------
  always_comb begin
    rd_data = '0;
    reg_err = 1'b0;
    case (reg_idx)
      REG_NTP_CONFIG: begin
        if (reg_rd) rd_data = ntp_config;
      end
      REG_RX_OFS: begin
        if (reg_rd) rd_data = rx_ofs;
      end
      REG_STATUS: begin
        if (reg_rd) rd_data = status_word;
        // Read only
        reg_err = reg_wr;
      end
      default: begin
        reg_err = reg_wr | reg_rd;
      end
    endcase
  end

  // The router strobes one access at a time
  assert property (@(posedge clk156) disable iff (reset)
    !(reg_wr && reg_rd))
    else $error("port_regs got read and write strobes together");

endmodule

// File: port_timestamp.sv
// Receive timestamp capture for one port
// On each receive marker with timestamping enabled, adds the port offset
// to the current NTP time and queues the result. Markers that find the
// queue full are dropped and counted
`timescale 1ns/1ps

module port_timestamp import ntps_pkg::*; (
  input  logic              clk156,
  input  logic              reset,
  input  logic              rx_mark,
  input  logic              ts_en,
  input  logic [REG_W-1:0]  rx_ofs,
  input  ntp_time_t         ntp_time,
  output ntp_time_t         ts_data,
  output logic              ts_valid,
  input  logic              ts_ready,
  output logic [DROP_W-1:0] drop_count
);

  logic      capture;
  logic      buf_ready;
  ntp_time_t stamp;

  assign capture = rx_mark & ts_en;

  // Offset goes onto the fraction, carry runs into seconds
  assign stamp = ntp_time + {{($bits(ntp_time_t) - REG_W){1'b0}}, rx_ofs};

  stream_buf #(
    .T (ntp_time_t)
  ) u_ts_buf (
    .clk156    (clk156),
    .reset     (reset),
    .in_data   (stamp),
    .in_valid  (capture),
    .in_ready  (buf_ready),
    .out_data  (ts_data),
    .out_valid (ts_valid),
    .out_ready (ts_ready)
  );

  // Lost markers, saturating
  always_ff @(posedge clk156) begin
    if (reset) begin
      drop_count <= '0;
    end else if (capture && !buf_ready && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

// File: stream_buf.sv
// Two-entry valid/ready buffer
// Keeps order, accepts and releases in the same cycle, and breaks the
// ready path so upstream never sees the downstream ready combinationally
`timescale 1ns/1ps

module stream_buf #(
  parameter type T = logic [7:0]
) (
  input  logic clk156,
  input  logic reset,
  input  T     in_data,
  input  logic in_valid,
  output logic in_ready,
  output T     out_data,
  output logic out_valid,
  input  logic out_ready
);

  T           mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign in_ready  = (count != 2'd2);
  assign out_valid = (count != 2'd0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Storage
  always_ff @(posedge clk156) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk156) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop)  rd_ptr <= ~rd_ptr;
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  // A stalled head entry is never overwritten by a push
  assert property (@(posedge clk156) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("stream_buf overflow, head entry changed while stalled");

endmodule

// File: vlog.f
ntps_pkg.sv
stream_buf.sv
ntp_clock.sv
port_regs.sv
port_timestamp.sv
api_router.sv
ntps_top.sv
ntps_tb.sv
